//--- logic/ads_reg_pkg.sv
package ads_reg_pkg;

    // word address and bus word widths of the host port
    localparam int ADDR_W = 4;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    // register map, one word per address
    localparam reg_addr_t REG_SOFT_RESET  = 4'd0;
    localparam reg_addr_t REG_AD_START    = 4'd2;
    localparam reg_addr_t REG_AD_RESET    = 4'd3;
    localparam reg_addr_t REG_AD_DRDY     = 4'd4;
    localparam reg_addr_t REG_SPI_TXBYTES = 4'd5;
    localparam reg_addr_t REG_SPI_TXDATA  = 4'd6;
    localparam reg_addr_t REG_SPI_RXDATA  = 4'd7;
    localparam reg_addr_t REG_SPI_RXREADY = 4'd8;
    localparam reg_addr_t REG_SPI_BUSY    = 4'd9;

    // returned for address 1 and anything above the map
    localparam reg_data_t RESERVED_READ = 32'hDEAD_BEEF;

endpackage

//--- logic/spi_pkg.sv
package spi_pkg;

    // n means n+1 bytes on the wire
    typedef logic [1:0] spi_bytes_t;

    // transmit word, low bytes sent msb first; receive word right-aligned
    typedef logic [31:0] spi_word_t;

    // clk cycles per half period of sclk
    localparam int SPI_HALF_PERIOD = 4;
    localparam int HALF_CNT_W = $clog2(SPI_HALF_PERIOD);

    // holds up to 32 bits
    localparam int BIT_CNT_W = 6;

endpackage

//--- logic/up_bus_if.sv
`timescale 1ns/1ps

interface up_bus_if import ads_reg_pkg::*; ();

    reg_addr_t wr_addr;
    logic      wr_req;
    reg_data_t wr_din;
    logic      wr_ack;

    reg_addr_t rd_addr;
    logic      rd_req;
    reg_data_t rd_dout;
    logic      rd_ack;

    // requests are single-cycle pulses, acked one cycle later
    modport host (
        output wr_addr, wr_req, wr_din, rd_addr, rd_req,
        input  wr_ack, rd_dout, rd_ack
    );

    modport regs (
        input  wr_addr, wr_req, wr_din, rd_addr, rd_req,
        output wr_ack, rd_dout, rd_ack
    );

endinterface

//--- logic/spi_xfer_if.sv
`timescale 1ns/1ps

interface spi_xfer_if import spi_pkg::*; ();

    spi_bytes_t tx_bytes;
    spi_word_t  tx_data;
    logic       tx_valid;
    spi_word_t  rx_data;
    logic       rx_valid;
    logic       busy;

    modport ctrl (
        output tx_bytes, tx_data, tx_valid,
        input  rx_data, rx_valid, busy
    );

    modport engine (
        input  tx_bytes, tx_data, tx_valid,
        output rx_data, rx_valid, busy
    );

endinterface

//--- logic/wb_up_bridge.sv
`timescale 1ns/1ps

module wb_up_bridge import ads_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  reg_addr_t wb_adr,
    input  reg_data_t wb_wdata,
    output reg_data_t wb_rdata,
    output logic      wb_ack,
    up_bus_if.host    up
);

    logic pending;
    logic start;

    // first cycle of a bus cycle that has not been forwarded yet
    assign start = wb_cyc && wb_stb && !pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            up.wr_req <= 1'b0;
            up.rd_req <= 1'b0;
        end else begin
            up.wr_req <= start && wb_we;
            up.rd_req <= start && !wb_we;
            if (start) begin
                pending <= 1'b1;
            end else if (up.wr_ack || up.rd_ack) begin
                pending <= 1'b0;
            end
        end
    end

    // master keeps address and data stable until ack
    assign up.wr_addr = wb_adr;
    assign up.wr_din  = wb_wdata;
    assign up.rd_addr = wb_adr;

    // ack and read data come straight back from the register port
    assign wb_ack   = up.wr_ack || up.rd_ack;
    assign wb_rdata = up.rd_dout;

endmodule

//--- logic/ads124x_regs.sv
`timescale 1ns/1ps

module ads124x_regs import ads_reg_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    up_bus_if.regs   up,
    spi_xfer_if.ctrl spi,
    input  logic     ad_drdy_n,
    output logic     ad_start,
    output logic     ad_reset,
    output logic     soft_reset
);

    logic [1:0] drdy_sync;
    logic       drdy;
    logic       rx_ready;
    reg_data_t  rx_word;
    logic       wr_txdata;

    assign wr_txdata = up.wr_req && (up.wr_addr == REG_SPI_TXDATA);

    // control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            soft_reset   <= 1'b0;
            ad_start     <= 1'b0;
            ad_reset     <= 1'b1;
            spi.tx_bytes <= '0;
        end else if (up.wr_req) begin
            case (up.wr_addr)
                REG_SOFT_RESET:  soft_reset   <= up.wr_din[0];
                REG_AD_START:    ad_start     <= up.wr_din[0];
                REG_AD_RESET:    ad_reset     <= up.wr_din[0];
                REG_SPI_TXBYTES: spi.tx_bytes <= up.wr_din[1:0];
                default: ;
            endcase
        end
    end

    // transmit word, the write itself launches the transfer
    always_ff @(posedge clk) begin
        if (wr_txdata) begin
            spi.tx_data <= up.wr_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spi.tx_valid <= 1'b0;
        end else begin
            spi.tx_valid <= wr_txdata;
        end
    end

    // ad_drdy_n is asynchronous to clk
    always_ff @(posedge clk) begin
        if (rst) begin
            drdy_sync <= 2'b11;
        end else begin
            drdy_sync <= {drdy_sync[0], ad_drdy_n};
        end
    end

    assign drdy = !drdy_sync[1];

    // received word and sticky ready flag, cleared when a new transfer is written
    always_ff @(posedge clk) begin
        if (spi.rx_valid) begin
            rx_word <= spi.rx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_ready <= 1'b0;
        end else if (wr_txdata) begin
            rx_ready <= 1'b0;
        end else if (spi.rx_valid) begin
            rx_ready <= 1'b1;
        end
    end

    // one cycle to ack either direction
    always_ff @(posedge clk) begin
        if (rst) begin
            up.wr_ack <= 1'b0;
            up.rd_ack <= 1'b0;
        end else begin
            up.wr_ack <= up.wr_req;
            up.rd_ack <= up.rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (up.rd_req) begin
            case (up.rd_addr)
                REG_SOFT_RESET:  up.rd_dout <= DATA_W'(soft_reset);
                REG_AD_START:    up.rd_dout <= DATA_W'(ad_start);
                REG_AD_RESET:    up.rd_dout <= DATA_W'(ad_reset);
                REG_AD_DRDY:     up.rd_dout <= DATA_W'(drdy);
                REG_SPI_TXBYTES: up.rd_dout <= DATA_W'(spi.tx_bytes);
                REG_SPI_TXDATA:  up.rd_dout <= spi.tx_data;
                REG_SPI_RXDATA:  up.rd_dout <= rx_word;
                REG_SPI_RXREADY: up.rd_dout <= DATA_W'(rx_ready);
                REG_SPI_BUSY:    up.rd_dout <= DATA_W'(spi.busy);
                default:         up.rd_dout <= RESERVED_READ;
            endcase
        end
    end

endmodule

//--- logic/spi_master.sv
`timescale 1ns/1ps

module spi_master import spi_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       soft_reset,
    spi_xfer_if.engine xfer,
    output logic       spi_sclk,
    output logic       spi_mosi,
    output logic       spi_cs_n,
    input  logic       spi_miso
);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } state_t;

    state_t                state;
    logic [HALF_CNT_W-1:0] half_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    spi_word_t             tx_shift;
    spi_word_t             rx_shift;
    logic                  accept;
    logic                  half_done;
    logic                  fall_tick;

    assign accept    = (state == IDLE) && xfer.tx_valid && !soft_reset;
    assign half_done = (half_cnt == HALF_CNT_W'(SPI_HALF_PERIOD - 1));
    // sclk about to fall and miso sampled here
    assign fall_tick = (state == SHIFT) && half_done && spi_sclk;

    always_ff @(posedge clk) begin
        if (rst || soft_reset) begin
            state    <= IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            spi_sclk <= 1'b0;
            spi_mosi <= 1'b0;
            spi_cs_n <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= SHIFT;
                        half_cnt <= '0;
                        bit_cnt  <= {1'b0, xfer.tx_bytes, 3'b000} + BIT_CNT_W'(8);
                        spi_cs_n <= 1'b0;
                    end
                end
                SHIFT: begin
                    if (half_done) begin
                        half_cnt <= '0;
                        spi_sclk <= !spi_sclk;
                        if (!spi_sclk) begin
                            // rising edge launches the next bit
                            spi_mosi <= tx_shift[31];
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                            if (bit_cnt == BIT_CNT_W'(1)) begin
                                state    <= DONE;
                                spi_cs_n <= 1'b1;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                default: begin
                    state    <= IDLE;
                    spi_mosi <= 1'b0;
                end
            endcase
        end
    end

    // first byte to send ends up in the top bits
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_shift <= xfer.tx_data << {~xfer.tx_bytes, 3'b000};
            rx_shift <= '0;
        end else if (fall_tick) begin
            tx_shift <= tx_shift << 1;
            rx_shift <= {rx_shift[30:0], spi_miso};
        end
    end

    assign xfer.busy     = (state != IDLE);
    assign xfer.rx_valid = (state == DONE);
    assign xfer.rx_data  = rx_shift;

endmodule

//--- logic/ads124x_ctrl.sv
`timescale 1ns/1ps

module ads124x_ctrl import ads_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  reg_addr_t wb_adr,
    input  reg_data_t wb_wdata,
    output reg_data_t wb_rdata,
    output logic      wb_ack,
    output logic      spi_sclk,
    output logic      spi_mosi,
    output logic      spi_cs_n,
    input  logic      spi_miso,
    output logic      ad_start,
    output logic      ad_reset,
    input  logic      ad_drdy_n
);

    logic soft_reset;

    up_bus_if   up_bus ();
    spi_xfer_if spi_xfer ();

    // host side
    wb_up_bridge u_bridge (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .up       (up_bus.host)
    );

    ads124x_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .up         (up_bus.regs),
        .spi        (spi_xfer.ctrl),
        .ad_drdy_n  (ad_drdy_n),
        .ad_start   (ad_start),
        .ad_reset   (ad_reset),
        .soft_reset (soft_reset)
    );

    // serial side
    spi_master u_spi (
        .clk        (clk),
        .rst        (rst),
        .soft_reset (soft_reset),
        .xfer       (spi_xfer.engine),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_cs_n   (spi_cs_n),
        .spi_miso   (spi_miso)
    );

endmodule

//--- sim/ads124x_ctrl_properties.sv
`timescale 1ns/1ps

module ads124x_ctrl_properties (
    input logic clk,
    input logic rst,
    input logic wb_ack,
    input logic spi_cs_n,
    input logic spi_sclk,
    input logic busy
);

    // one ack per bus cycle
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles in a row");

    // chip select released whenever the engine is idle
    cs_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> spi_cs_n)
        else $error("spi_cs_n low while the SPI master is idle");

    // mode 1 clock idles low outside a frame
    sclk_idle: assert property (@(posedge clk) disable iff (rst) spi_cs_n |-> !spi_sclk)
        else $error("spi_sclk high while spi_cs_n is released");

endmodule

bind ads124x_ctrl ads124x_ctrl_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .wb_ack   (wb_ack),
    .spi_cs_n (spi_cs_n),
    .spi_sclk (spi_sclk),
    .busy     (spi_xfer.busy)
);

//--- sim/ads124x_ctrl_tb.sv
`timescale 1ns/1ps

module ads124x_ctrl_tb import ads_reg_pkg::*, spi_pkg::*; ();

    logic      clk = 1'b0;
    logic      rst;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    reg_addr_t wb_adr;
    reg_data_t wb_wdata;
    reg_data_t wb_rdata;
    logic      wb_ack;
    logic      spi_sclk;
    logic      spi_mosi;
    logic      spi_cs_n;
    logic      spi_miso;
    logic      ad_start;
    logic      ad_reset;
    logic      ad_drdy_n;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_POLL, OP_WAIT, OP_PINS} op_t;

    // one table row; for OP_PINS exp holds {spi_cs_n, ad_reset, ad_start}
    typedef struct packed {
        op_t       op;
        reg_addr_t addr;
        reg_data_t wdata;
        logic      drdy_n;
        reg_data_t exp;
    } row_t;

    row_t   rows[$];
    integer seed = 32'ha61e_e5c2;
    int     errors = 0;
    int     n_access = 0;
    int     n_ack = 0;
    int     n_xfer = 0;
    int     cycles = 0;
    int     limit = 0;

    // loopback, the ADC side is not modeled
    assign spi_miso = spi_mosi;

    ads124x_ctrl UUT (.*);

    always #50 clk = ~clk;

    // run limit, set once the table is built
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (wb_ack)
                n_ack++;
            if (spi_cs_n)
                check_bit("spi_sclk", 1'b0, spi_sclk);
        end
    end

    task automatic check_word(input string name, input reg_data_t exp, input reg_data_t act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // received word is the low n+1 bytes of what was sent
    function automatic reg_data_t low_bytes(input reg_data_t word, input spi_bytes_t n);
        reg_data_t mask;
        mask = '1;
        mask = mask >> (8 * (3 - int'(n)));
        return word & mask;
    endfunction

    task automatic add_row(input op_t op, input reg_addr_t addr, input reg_data_t wdata,
                           input logic drdy_n, input reg_data_t exp);
        if (op == OP_WR && addr == REG_SPI_TXDATA)
            n_xfer++;
        rows.push_back(row_t'{op, addr, wdata, drdy_n, exp});
    endtask

    // one Wishbone classic cycle, held until ack
    task automatic wb_access(input logic we, input reg_addr_t adr, input reg_data_t wdata,
                             output reg_data_t rdata);
        @(posedge clk);
        #5;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_wdata = wdata;
        n_access++;
        do begin
            @(posedge clk);
            #5;
        end while (!wb_ack);
        rdata = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic poll_rx_ready();
        reg_data_t rd;
        rd = '0;
        while (rd !== 32'd1)
            wb_access(1'b0, REG_SPI_RXREADY, '0, rd);
    endtask

    task automatic apply_row(input row_t r);
        reg_data_t rd;
        ad_drdy_n = r.drdy_n;
        case (r.op)
            OP_WR: wb_access(1'b1, r.addr, r.wdata, rd);
            OP_RD: begin
                wb_access(1'b0, r.addr, '0, rd);
                check_word($sformatf("wb_rdata at address %0d", r.addr), r.exp, rd);
            end
            OP_POLL: poll_rx_ready();
            OP_WAIT: begin
                repeat (r.wdata) @(posedge clk);
                #5;
            end
            default: begin
                check_bit("ad_start", r.exp[0], ad_start);
                check_bit("ad_reset", r.exp[1], ad_reset);
                check_bit("spi_cs_n", r.exp[2], spi_cs_n);
            end
        endcase
    endtask

    task automatic build_table();
        reg_data_t word;
        // values after reset
        add_row(OP_RD, REG_SOFT_RESET, '0, 1'b1, 32'd0);
        add_row(OP_RD, REG_AD_START, '0, 1'b1, 32'd0);
        add_row(OP_RD, REG_AD_RESET, '0, 1'b1, 32'd1);
        add_row(OP_RD, REG_AD_DRDY, '0, 1'b1, 32'd0);
        add_row(OP_RD, REG_SPI_RXREADY, '0, 1'b1, 32'd0);
        add_row(OP_RD, REG_SPI_BUSY, '0, 1'b1, 32'd0);
        add_row(OP_PINS, '0, '0, 1'b1, 32'b110);
        for (int a = 1; a < 16; a++) begin
            if (a == 1 || a >= 10)
                add_row(OP_RD, reg_addr_t'(a), '0, 1'b1, 32'hDEAD_BEEF);
        end
        // control bits, only bit 0 is kept
        word = $random(seed);
        add_row(OP_WR, REG_AD_START, word | 32'd1, 1'b1, '0);
        add_row(OP_RD, REG_AD_START, '0, 1'b1, 32'd1);
        word = $random(seed);
        add_row(OP_WR, REG_AD_RESET, word & ~32'd1, 1'b1, '0);
        add_row(OP_RD, REG_AD_RESET, '0, 1'b1, 32'd0);
        add_row(OP_PINS, '0, '0, 1'b1, 32'b101);
        word = $random(seed);
        add_row(OP_WR, REG_SOFT_RESET, word | 32'd1, 1'b1, '0);
        add_row(OP_RD, REG_SOFT_RESET, '0, 1'b1, 32'd1);
        add_row(OP_WR, REG_SOFT_RESET, word & ~32'd1, 1'b1, '0);
        add_row(OP_RD, REG_SOFT_RESET, '0, 1'b1, 32'd0);
        add_row(OP_WR, REG_AD_START, '0, 1'b1, '0);
        add_row(OP_WR, REG_AD_RESET, 32'd1, 1'b1, '0);
        add_row(OP_PINS, '0, '0, 1'b1, 32'b110);
        // drdy goes through two flops
        add_row(OP_WAIT, '0, 32'd4, 1'b0, '0);
        add_row(OP_RD, REG_AD_DRDY, '0, 1'b0, 32'd1);
        add_row(OP_WAIT, '0, 32'd4, 1'b1, '0);
        add_row(OP_RD, REG_AD_DRDY, '0, 1'b1, 32'd0);
        for (int n = 0; n < 4; n++) begin
            word = $random(seed);
            add_row(OP_WR, REG_SPI_TXBYTES, reg_data_t'(n), 1'b1, '0);
            add_row(OP_WR, REG_SPI_TXDATA, word, 1'b1, '0);
            add_row(OP_POLL, '0, '0, 1'b1, '0);
            add_row(OP_RD, REG_SPI_RXDATA, '0, 1'b1, low_bytes(word, spi_bytes_t'(n)));
        end
        // abort a 4-byte frame with soft reset
        word = $random(seed);
        add_row(OP_WR, REG_SPI_TXBYTES, 32'd3, 1'b1, '0);
        add_row(OP_WR, REG_SPI_TXDATA, word, 1'b1, '0);
        add_row(OP_RD, REG_SPI_BUSY, '0, 1'b1, 32'd1);
        add_row(OP_WR, REG_SOFT_RESET, 32'd1, 1'b1, '0);
        add_row(OP_WR, REG_SOFT_RESET, 32'd0, 1'b1, '0);
        add_row(OP_RD, REG_SPI_BUSY, '0, 1'b1, 32'd0);
        add_row(OP_RD, REG_SPI_RXREADY, '0, 1'b1, 32'd0);
        add_row(OP_PINS, '0, '0, 1'b1, 32'b110);
    endtask

    initial begin
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_wdata = '0;
        ad_drdy_n = 1'b1;
        build_table();
        // 20 cycles per row plus a full 32-bit frame per launched transfer
        limit = rows.size() * 20 + n_xfer * (32 * 2 * SPI_HALF_PERIOD + 20);
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        foreach (rows[i])
            apply_row(rows[i]);
        repeat (2) @(posedge clk);
        check_word("wb_ack count", reg_data_t'(n_access), reg_data_t'(n_ack));
        $display("Finished %0d rows with %0d errors", rows.size(), errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- ads124x_ctrl.f
logic/ads_reg_pkg.sv
logic/spi_pkg.sv
logic/up_bus_if.sv
logic/spi_xfer_if.sv
logic/wb_up_bridge.sv
logic/ads124x_regs.sv
logic/spi_master.sv
logic/ads124x_ctrl.sv
sim/ads124x_ctrl_properties.sv
sim/ads124x_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ads124x_ctrl_tb
FILELIST  ?= ads124x_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard logic/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
